// ==== rtl/vidbw_pkg.sv ====
// --------------------------------------------------
// video bandwidth filter: shared widths, FIR taps and
// sequencer state encoding
// --------------------------------------------------
package vidbw_pkg;

    // channel widths
    localparam int WIN   = 4;               // colour bits in, per channel
    localparam int WOUT  = 5;               // colour bits out, per channel
    localparam int WC    = 5;               // coefficient bits

    // filter shape
    localparam int NTAP  = 5;               // fixed filter order
    localparam int TAP_W = 3;               // enough for 0..NTAP-1

    // accumulator and scaling
    localparam int AW    = WIN + WC + 3;    // 12 bits, room for NTAP products
    localparam int SHIFT = WC - (WOUT - WIN); // gain 34/16 then widen

    // last tap index, sized for the tap counter
    localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(NTAP - 1);

    // saturation ceiling of the output word
    localparam logic [WOUT-1:0] OUT_MAX = {WOUT{1'b1}};

    // low-pass kernel, tap 0 is the newest sample
    // sum is 34 so a full-scale input saturates after scaling
    localparam logic [WC-1:0] COEFF [NTAP] = '{
        5'd0,   // tap 0
        5'd7,   // tap 1
        5'd20,  // tap 2, centre
        5'd7,   // tap 3
        5'd0    // tap 4
    };

    // tap sequencer states
    typedef enum logic {
        SEQ_IDLE = 1'b0,    // waiting for a strobe
        SEQ_MAC  = 1'b1     // stepping through the taps
    } seq_state_t;

endpackage

// ==== rtl/vidbw_seq.sv ====
// --------------------------------------------------
// tap sequencer: one capture per strobe, then NTAP
// MAC steps shared by all colour channels
// --------------------------------------------------
`timescale 1ns/1ps

module vidbw_seq
    import vidbw_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             spl_in,     // pixel strobe, one cycle
    output logic             capture,    // shift in sample, clear acc
    output logic             mac_step,   // accumulate one tap
    output logic [TAP_W-1:0] tap_idx     // tap selected this cycle
);

    seq_state_t state;
    seq_state_t state_nxt;
    logic       last_tap;

    assign last_tap = (tap_idx == LAST_TAP);   // final product this cycle

    // next state
    always_comb begin
        state_nxt = state;
        if (spl_in) begin
            state_nxt = SEQ_MAC;    // strobe always (re)starts the window
        end else begin
            case (state)
                SEQ_IDLE: state_nxt = SEQ_IDLE;
                SEQ_MAC:  state_nxt = last_tap ? SEQ_IDLE : SEQ_MAC;
                default:  state_nxt = SEQ_IDLE;
            endcase
        end
    end

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // tap counter, runs only while stepping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_idx <= '0;
        end else if (spl_in) begin
            tap_idx <= '0;                      // first MAC uses tap 0
        end else if (state == SEQ_MAC) begin
            if (last_tap) begin
                tap_idx <= '0;                  // park at 0 between pixels
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    // the capture edge coincides with the strobe edge, so the
    // channels see the new sample and the window result together
    assign capture  = spl_in;
    assign mac_step = (state == SEQ_MAC);    // NTAP cycles after capture

endmodule

// ==== rtl/vidbw_fir.sv ====
// --------------------------------------------------
// colour channel FIR: sample history, shared-tap MAC,
// saturation and bypass widening
// --------------------------------------------------
`timescale 1ns/1ps

module vidbw_fir
    import vidbw_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             capture,    // new pixel this cycle
    input  logic             mac_step,   // add one product
    input  logic [TAP_W-1:0] tap_idx,    // which tap to add
    input  logic             enable,     // low = bypass filter
    input  logic [WIN-1:0]   din,
    output logic [WOUT-1:0]  dout
);

    logic [WIN-1:0]     hist [NTAP];    // tap 0 newest
    logic [AW-1:0]      acc;
    logic [WC-1:0]      coef_sel;
    logic [WIN-1:0]     samp_sel;
    logic [WIN+WC-1:0]  prod;
    logic [AW-1:0]      scaled;
    logic [WOUT-1:0]    result;
    logic [WOUT-1:0]    dout_q;         // filtered pixel, one sample late
    logic [WOUT-1:0]    din_wide;

    // tap select, out-of-range index contributes nothing
    always_comb begin
        coef_sel = '0;
        samp_sel = '0;
        if (tap_idx < TAP_W'(NTAP)) begin
            coef_sel = COEFF[tap_idx];
            samp_sel = hist[tap_idx];
        end
    end

    assign prod = coef_sel * samp_sel;  // 9-bit product

    // sample history, shifts on every strobe even in bypass
    // so the filter is primed when enable comes back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NTAP; i++) begin
                hist[i] <= '0;
            end
        end else if (capture) begin
            hist[0] <= din;
            for (int i = 1; i < NTAP; i++) begin
                hist[i] <= hist[i-1];   // age by one pixel
            end
        end
    end

    // accumulator, cleared at capture, then NTAP adds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (capture) begin
            acc <= '0;                  // capture wins over a late step
        end else if (mac_step) begin
            acc <= acc + AW'(prod);
        end
    end

    // scale down and clip to the output range
    assign scaled = acc >> SHIFT;
    assign result = (scaled > AW'(OUT_MAX)) ? OUT_MAX : scaled[WOUT-1:0];

    // previous window is complete by the next strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_q <= '0;
        end else if (capture) begin
            dout_q <= result;
        end
    end

    // widen by repeating the top bits into the new lsbs
    assign din_wide = {din, din[WIN-1 -: (WOUT-WIN)]};

    // bypass is combinational, zero latency
    assign dout = enable ? dout_q : din_wide;

endmodule

// ==== rtl/vidbw_sync_dly.sv ====
// --------------------------------------------------
// sync/blank delay: holds timing bits one pixel to
// stay aligned with the filtered colour
// --------------------------------------------------
`timescale 1ns/1ps

module vidbw_sync_dly (
    input  logic clk,
    input  logic rst_n,
    input  logic spl_in,    // pixel strobe, loads the delay
    input  logic enable,    // low = pass through
    input  logic hs_in,
    input  logic vs_in,
    input  logic hb_in,
    input  logic vb_in,
    output logic hs_out,
    output logic vs_out,
    output logic hb_out,
    output logic vb_out
);

    logic [3:0] sync_now;   // {hs, vs, hb, vb}
    logic [3:0] sync_cap;   // taken at this strobe
    logic [3:0] sync_dly;   // previous strobe, goes out with its colour

    assign sync_now = {hs_in, vs_in, hb_in, vb_in};

    // loads on every strobe regardless of enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_cap <= '0;
            sync_dly <= '0;
        end else if (spl_in) begin
            sync_cap <= sync_now;
            sync_dly <= sync_cap;   // one pixel behind, like the FIR output
        end
    end

    // delayed when filtering, straight through in bypass
    assign {hs_out, vs_out, hb_out, vb_out} = enable ? sync_dly : sync_now;

endmodule

// ==== rtl/vidbw_top.sv ====
// --------------------------------------------------
// video bandwidth filter top: sequencer, RGB FIRs
// and sync delay
// --------------------------------------------------
`timescale 1ns/1ps

module vidbw_top
    import vidbw_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            spl_in,     // one pulse per pixel
    input  logic            enable,     // low = bypass
    input  logic [WIN-1:0]  r_in,
    input  logic [WIN-1:0]  g_in,
    input  logic [WIN-1:0]  b_in,
    input  logic            hs_in,
    input  logic            vs_in,
    input  logic            hb_in,
    input  logic            vb_in,
    output logic [WOUT-1:0] r_out,
    output logic [WOUT-1:0] g_out,
    output logic [WOUT-1:0] b_out,
    output logic            hs_out,
    output logic            vs_out,
    output logic            hb_out,
    output logic            vb_out
);

    logic             capture;
    logic             mac_step;
    logic [TAP_W-1:0] tap_idx;

    // one tap sequence shared by all three channels
    vidbw_seq u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .spl_in   (spl_in),
        .capture  (capture),
        .mac_step (mac_step),
        .tap_idx  (tap_idx)
    );

    vidbw_fir u_fir_r (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .mac_step (mac_step),
        .tap_idx  (tap_idx),
        .enable   (enable),
        .din      (r_in),
        .dout     (r_out)
    );

    vidbw_fir u_fir_g (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .mac_step (mac_step),
        .tap_idx  (tap_idx),
        .enable   (enable),
        .din      (g_in),
        .dout     (g_out)
    );

    vidbw_fir u_fir_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .mac_step (mac_step),
        .tap_idx  (tap_idx),
        .enable   (enable),
        .din      (b_in),
        .dout     (b_out)
    );

    // timing bits, same one-pixel lag as the colour
    vidbw_sync_dly u_sync_dly (
        .clk    (clk),
        .rst_n  (rst_n),
        .spl_in (spl_in),
        .enable (enable),
        .hs_in  (hs_in),
        .vs_in  (vs_in),
        .hb_in  (hb_in),
        .vb_in  (vb_in),
        .hs_out (hs_out),
        .vs_out (vs_out),
        .hb_out (hb_out),
        .vb_out (vb_out)
    );

endmodule

// ==== bench/vidbw_tb.sv ====
// --------------------------------------------------
// testbench for the video bandwidth filter, random
// pixels checked against a reference FIR model
// --------------------------------------------------
`timescale 1ns/1ps

module vidbw_tb
    import vidbw_pkg::*;
;

    logic            clk;
    logic            rst_n;
    logic            spl_in;
    logic            enable;
    logic [WIN-1:0]  r_in;
    logic [WIN-1:0]  g_in;
    logic [WIN-1:0]  b_in;
    logic            hs_in;
    logic            vs_in;
    logic            hb_in;
    logic            vb_in;
    logic [WOUT-1:0] r_out;
    logic [WOUT-1:0] g_out;
    logic [WOUT-1:0] b_out;
    logic            hs_out;
    logic            vs_out;
    logic            hb_out;
    logic            vb_out;

    logic [3:0]  sync_in_vec;   // {hs, vs, hb, vb}
    logic [3:0]  sync_out_vec;
    logic [31:0] lfsr_state;

    // reference model state, index 0 newest
    logic [NTAP-1:0][WIN-1:0] hist_r;
    logic [NTAP-1:0][WIN-1:0] hist_g;
    logic [NTAP-1:0][WIN-1:0] hist_b;
    logic [WOUT-1:0] exp_r;
    logic [WOUT-1:0] exp_g;
    logic [WOUT-1:0] exp_b;
    logic [3:0]      sync_q;    // bits held from the latest strobe
    logic [3:0]      exp_sync;  // bits from the strobe before

    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    test_err_start;
    string test_name;

    assign sync_in_vec  = {hs_in, vs_in, hb_in, vb_in};
    assign sync_out_vec = {hs_out, vs_out, hb_out, vb_out};

    vidbw_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .spl_in (spl_in),
        .enable (enable),
        .r_in   (r_in),
        .g_in   (g_in),
        .b_in   (b_in),
        .hs_in  (hs_in),
        .vs_in  (vs_in),
        .hb_in  (hb_in),
        .vb_in  (vb_in),
        .r_out  (r_out),
        .g_out  (g_out),
        .b_out  (b_out),
        .hs_out (hs_out),
        .vs_out (vs_out),
        .hb_out (hb_out),
        .vb_out (vb_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // input in the top bits, its msbs repeated below
    function automatic logic [WOUT-1:0] widen_ref(input logic [WIN-1:0] x);
        int w;
        w = (int'(x) << (WOUT - WIN)) | (int'(x) >> (2 * WIN - WOUT));
        return WOUT'(w);
    endfunction

    function automatic logic [WOUT-1:0] fir_ref(input logic [NTAP-1:0][WIN-1:0] h);
        int sum;
        sum = 0;
        for (int i = 0; i < NTAP; i++) begin
            sum += int'(COEFF[i]) * int'(h[i]);
        end
        sum = sum >> SHIFT;
        if (sum > (1 << WOUT) - 1) begin
            sum = (1 << WOUT) - 1;  // clip to all ones
        end
        return WOUT'(sum);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] act,
                                 input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: actual 0x%0h, expected 0x%0h at %0t",
                     name, act, exp, $time);
        end
    endtask

    // window result goes out, then the new sample goes in
    task automatic model_strobe();
        exp_r    = fir_ref(hist_r);
        exp_g    = fir_ref(hist_g);
        exp_b    = fir_ref(hist_b);
        hist_r   = {hist_r[NTAP-2:0], r_in};
        hist_g   = {hist_g[NTAP-2:0], g_in};
        hist_b   = {hist_b[NTAP-2:0], b_in};
        exp_sync = sync_q;
        sync_q   = sync_in_vec;
    endtask

    task automatic check_outputs();
        if (enable) begin
            compare_value("r_out", 32'(r_out), 32'(exp_r));
            compare_value("g_out", 32'(g_out), 32'(exp_g));
            compare_value("b_out", 32'(b_out), 32'(exp_b));
            compare_value("sync_out", 32'(sync_out_vec), 32'(exp_sync));
        end else begin
            compare_value("r_out", 32'(r_out), 32'(widen_ref(r_in)));
            compare_value("g_out", 32'(g_out), 32'(widen_ref(g_in)));
            compare_value("b_out", 32'(b_out), 32'(widen_ref(b_in)));
            compare_value("sync_out", 32'(sync_out_vec), 32'(sync_in_vec));
        end
    endtask

    // the tap sequence must be idle before the next strobe
    task automatic wait_seq_idle();
        int n;
        n = 0;
        while (dut_i.mac_step && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dut_i.mac_step) begin
            $display("timeout: tap sequence still running after %0d clocks", n);
            $display("Done: errors found");
            $finish;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_pixel(input logic [WIN-1:0] r, input logic [WIN-1:0] g,
                              input logic [WIN-1:0] b, input logic [3:0] sync,
                              input logic en, input int gap);
        r_in   = r;
        g_in   = g;
        b_in   = b;
        {hs_in, vs_in, hb_in, vb_in} = sync;
        enable = en;
        spl_in = 1'b1;
        #3;
        if (!en) begin
            check_outputs();    // bypass shows up before the strobe edge
        end
        @(posedge clk);         // strobe sampled here
        #1;
        spl_in = 1'b0;
        model_strobe();
        #3;
        check_outputs();
        repeat (gap - 1) @(posedge clk);
        #1;
        wait_seq_idle();
    endtask

    task automatic send_random_pixel(input logic en);
        logic [WIN-1:0] r;
        logic [WIN-1:0] g;
        logic [WIN-1:0] b;
        logic [3:0]     s;
        int             gap;
        r   = WIN'(take_bits(WIN));
        g   = WIN'(take_bits(WIN));
        b   = WIN'(take_bits(WIN));
        s   = 4'(take_bits(4));
        gap = 6 + int'(take_bits(2));   // 6 to 9 clocks
        send_pixel(r, g, b, s, en, gap);
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        int n;
        n = errors - test_err_start;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0d %-16s %s, %0d errors", tests_run, test_name,
                 (n == 0) ? "ok" : "FAILED", n);
    endtask

    initial begin
        int n_off;
        lfsr_state = 32'h93ac;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        spl_in = 1'b0;
        enable = 1'b1;
        r_in = '0;
        g_in = '0;
        b_in = '0;
        {hs_in, vs_in, hb_in, vb_in} = 4'h0;
        hist_r = '0;
        hist_g = '0;
        hist_b = '0;
        exp_r = '0;
        exp_g = '0;
        exp_b = '0;
        sync_q = '0;
        exp_sync = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset");
        r_in = WIN'(take_bits(WIN)) | WIN'(1);  // nonzero inputs must not leak through
        g_in = WIN'(take_bits(WIN)) | WIN'(1);
        b_in = WIN'(take_bits(WIN)) | WIN'(1);
        {hs_in, vs_in, hb_in, vb_in} = 4'hf;
        #3;
        check_outputs();
        repeat (3) @(posedge clk);
        #1;
        check_outputs();
        finish_test();

        start_test("bypass");
        for (int i = 0; i < 50; i++) begin
            send_random_pixel(1'b0);
        end
        finish_test();

        start_test("filtered");
        for (int i = 0; i < 300; i++) begin
            send_random_pixel(1'b1);
        end
        finish_test();

        start_test("saturation");
        for (int i = 0; i < 10; i++) begin
            send_pixel({WIN{1'b1}}, {WIN{1'b1}}, {WIN{1'b1}}, 4'(take_bits(4)),
                       1'b1, 6 + int'(take_bits(2)));
            if (i >= 5) begin
                compare_value("r_out max", 32'(r_out), 32'({WOUT{1'b1}}));
                compare_value("g_out max", 32'(g_out), 32'({WOUT{1'b1}}));
                compare_value("b_out max", 32'(b_out), 32'({WOUT{1'b1}}));
            end
        end
        finish_test();

        start_test("sync alignment");
        for (int i = 0; i < 60; i++) begin
            send_random_pixel(1'b1);
        end
        finish_test();

        start_test("enable toggle");
        for (int k = 0; k < 8; k++) begin
            n_off = 1 + int'(take_bits(2));     // 1 to 4 bypassed pixels
            for (int i = 0; i < n_off; i++) begin
                send_random_pixel(1'b0);
            end
            for (int i = 0; i < 6; i++) begin
                send_random_pixel(1'b1);
            end
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/vidbw_pkg.sv
rtl/vidbw_seq.sv
rtl/vidbw_fir.sv
rtl/vidbw_sync_dly.sv
rtl/vidbw_top.sv
bench/vidbw_tb.sv

// ==== Makefile ====
# Verilator build and run for the video bandwidth filter

VERILATOR  ?= verilator
TOP        ?= vidbw_tb
RTL_TOP    ?= vidbw_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Done: no errors
FAIL_MSG   ?= Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
